// ==== bench/memStageStimulus.txt ====
# test kind opcode address storeData stall pc expected  (test decimal, the rest hex)
# kind st store, ld load (no loadValid expected when stall is 1), fe fetch via fetchAddr
1 st 2b 10000010 deadbeef 0 00000000 00000000
1 ld 23 10000010 00000000 0 00000000 deadbeef
1 st 2b 10000014 12345678 0 00000000 00000000
1 ld 23 10000014 00000000 0 00000000 12345678
1 ld 23 10000010 00000000 0 00000000 deadbeef
2 st 2b 10000020 11223344 0 00000000 00000000
2 st 28 10000020 000000a5 0 00000000 00000000
2 ld 23 10000020 00000000 0 00000000 a5223344
2 st 28 10000021 ffffff7f 0 00000000 00000000
2 ld 23 10000020 00000000 0 00000000 a57f3344
2 st 28 10000022 00000080 0 00000000 00000000
2 ld 23 10000020 00000000 0 00000000 a57f8044
2 st 28 10000023 00000001 0 00000000 00000000
2 ld 23 10000020 00000000 0 00000000 a57f8001
2 ld 20 10000020 00000000 0 00000000 ffffffa5
2 ld 24 10000020 00000000 0 00000000 000000a5
2 ld 20 10000021 00000000 0 00000000 0000007f
2 ld 24 10000021 00000000 0 00000000 0000007f
2 ld 20 10000022 00000000 0 00000000 ffffff80
2 ld 24 10000022 00000000 0 00000000 00000080
2 ld 20 10000023 00000000 0 00000000 00000001
2 ld 24 10000023 00000000 0 00000000 00000001
3 st 2b 10000030 55667788 0 00000000 00000000
3 st 29 10000030 1234c3d2 0 00000000 00000000
3 ld 23 10000030 00000000 0 00000000 c3d27788
3 st 29 10000032 00007a01 0 00000000 00000000
3 ld 23 10000030 00000000 0 00000000 c3d27a01
3 ld 21 10000030 00000000 0 00000000 ffffc3d2
3 ld 25 10000030 00000000 0 00000000 0000c3d2
3 ld 21 10000032 00000000 0 00000000 00007a01
3 ld 25 10000032 00000000 0 00000000 00007a01
3 st 29 10000032 0000fedc 0 00000000 00000000
3 ld 21 10000032 00000000 0 00000000 fffffedc
3 ld 25 10000032 00000000 0 00000000 0000fedc
4 st 2b 10000040 0a0b0c0d 0 00000000 00000000
4 st 2b 10000040 ffffffff 1 00000000 00000000
4 ld 23 10000040 00000000 0 00000000 0a0b0c0d
4 st 28 10000041 00000099 1 00000000 00000000
4 ld 23 10000040 00000000 0 00000000 0a0b0c0d
4 ld 23 10000040 00000000 1 00000000 00000000
4 ld 20 10000041 00000000 1 00000000 00000000
4 st 2b 20000040 13579bdf 0 40000000 00000000
4 fe 00 20000040 00000000 0 00000000 13579bdf
4 st 2b 20000040 00000000 1 40000000 00000000
4 fe 00 20000040 00000000 0 00000000 13579bdf
4 ld 23 10000040 00000000 0 00000000 0a0b0c0d
5 st 2b 10000100 77777777 0 00000000 00000000
5 st 2b 20000100 aabbccdd 0 40000000 00000000
5 fe 00 20000100 00000000 0 00000000 aabbccdd
5 st 2b 20000100 01020304 0 00400000 00000000
5 fe 00 20000100 00000000 0 00000000 aabbccdd
5 st 28 20000102 000000ee 0 40000000 00000000
5 fe 00 20000100 00000000 0 00000000 aabbeedd
5 st 2b 30000104 cafef00d 0 40000000 00000000
5 fe 00 30000104 00000000 0 00000000 cafef00d
5 ld 23 10000104 00000000 0 00000000 cafef00d
5 st 2b 20000108 0badc0de 0 40000000 00000000
5 st 2b 10000108 600dd00d 0 00000000 00000000
5 st 2b 30000108 5a5a5a5a 0 00000000 00000000
5 ld 23 10000108 00000000 0 00000000 5a5a5a5a
5 fe 00 20000108 00000000 0 00000000 0badc0de
5 ld 23 10000100 00000000 0 00000000 77777777
6 st 2b 10000140 a1a2a3a4 0 00000000 00000000
6 st 2b 20000140 b1b2b3b4 0 40000000 00000000
6 st 2b 00000140 ffffffff 0 40000000 00000000
6 st 2b 40000140 eeeeeeee 0 40000000 00000000
6 st 2b 70000140 dddddddd 0 40000000 00000000
6 st 2b b0000140 cccccccc 0 40000000 00000000
6 st 28 50000141 00000000 0 40000000 00000000
6 ld 23 10000140 00000000 0 00000000 a1a2a3a4
6 fe 00 20000140 00000000 0 00000000 b1b2b3b4

// ==== bench/memStageTb.sv ====
module memStageTb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int clkHalf      = 10;   // 20 ns period
   localparam int resetCycles  = 8;
   localparam int driveDelay   = 2;    // inputs change this long after the edge
   localparam int validTimeout = 4;    // cycles allowed for loadValid
   localparam int quietCycles  = 3;    // cycles a dropped load is watched

   logic        clk;
   logic        rstN;
   logic [5:0]  opcode;
   logic [31:0] aluOut;
   logic [31:0] storeData;
   logic        stall;
   logic [31:0] pc;
   logic [31:0] fetchAddr;
   logic [31:0] loadData;
   logic        loadValid;
   logic [31:0] instrWord;

   int          fd;
   int          curTest;
   int          testErrors;
   int          totalErrors;
   int          passCount;
   int          failCount;
   int          lineNo;
   int          nItems;
   int          testNum;
   string       lineText;
   logic [15:0] kind;            // two-letter operation kind
   logic [31:0] opVal;
   logic [31:0] addrVal;
   logic [31:0] dataVal;
   logic [31:0] stallVal;
   logic [31:0] pcVal;
   logic [31:0] expVal;

   memStage #(
      .dataAddrW  (10),
      .instrAddrW (10)
   ) u_memStage (
      .clk       (clk),
      .rstN      (rstN),
      .opcode    (opcode),
      .aluOut    (aluOut),
      .storeData (storeData),
      .stall     (stall),
      .pc        (pc),
      .fetchAddr (fetchAddr),
      .loadData  (loadData),
      .loadValid (loadValid),
      .instrWord (instrWord)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #clkHalf clk = ~clk;
      end
   end

   // bubble on the stage inputs with the fetch port left alone
   task automatic applyIdle();
      opcode    = 6'h00;
      aluOut    = 32'h0;
      storeData = 32'h0;
      stall     = 1'b0;
      pc        = 32'h0;
   endtask

   task automatic noteMismatch(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
      $display("MISMATCH at %0d ns: test %0d %s got %h expected %h",
               $time, curTest, what, got, exp);
      testErrors++;
      totalErrors++;
   endtask

   task automatic noteFailure(input string msg);
      $display("ERROR at %0d ns: test %0d %s", $time, curTest, msg);
      testErrors++;
      totalErrors++;
   endtask

   task automatic closeTest();
      if (testErrors == 0) begin
         passCount++;
         $display("test %0d ok", curTest);
      end else begin
         failCount++;
         $display("test %0d failed with %0d errors", curTest, testErrors);
      end
   endtask

   task automatic runStore(input logic [5:0] op, input logic [31:0] addr,
                           input logic [31:0] data, input logic stallIn,
                           input logic [31:0] pcIn);
      opcode    = op;
      aluOut    = addr;
      storeData = data;
      stall     = stallIn;
      pc        = pcIn;
      @(posedge clk);            // write lands on this edge
      #driveDelay;
      applyIdle();
   endtask

   task automatic runLoad(input logic [5:0] op, input logic [31:0] addr,
                          input logic [31:0] exp);
      int          waited;
      bit          seen;
      logic [31:0] got;
      waited = 0;
      seen   = 1'b0;
      got    = 32'h0;
      opcode = op;
      aluOut = addr;
      stall  = 1'b0;
      while (!seen && waited < validTimeout) begin
         @(posedge clk);
         #1;                     // outputs settled before the next drive
         waited++;
         if (loadValid) begin
            seen = 1'b1;
            got  = loadData;
         end
         #(driveDelay - 1);
         applyIdle();
      end
      if (!seen) begin
         noteFailure($sformatf("no loadValid within %0d cycles for load from %h",
                               validTimeout, addr));
      end else if (waited != 1) begin
         noteFailure($sformatf("loadValid came %0d cycles after the load from %h, not 1",
                               waited, addr));
      end else if (got !== exp) begin
         noteMismatch($sformatf("load op %h from %h", op, addr), got, exp);
      end
   endtask

   // the load must vanish, so watch a few cycles for a stray valid
   task automatic runStalledLoad(input logic [5:0] op, input logic [31:0] addr);
      int waited;
      waited = 0;
      opcode = op;
      aluOut = addr;
      stall  = 1'b1;
      while (waited < quietCycles) begin
         @(posedge clk);
         #1;
         waited++;
         if (loadValid) begin
            noteFailure($sformatf("loadValid rose for a load from %h issued under stall",
                                  addr));
         end
         #(driveDelay - 1);
         applyIdle();
      end
   endtask

   task automatic runFetch(input logic [31:0] addr, input logic [31:0] exp);
      logic [31:0] got;
      fetchAddr = addr;
      @(posedge clk);
      #1;
      got = instrWord;
      #(driveDelay - 1);
      if (got !== exp) begin
         noteMismatch($sformatf("fetch from %h", addr), got, exp);
      end
   endtask

   task automatic runLine();
      if (lineText.len() < 2 || lineText[0] == "#") begin
         return;                 // blank or comment
      end
      nItems = $sscanf(lineText, "%d %s %h %h %h %h %h %h", testNum, kind, opVal,
                       addrVal, dataVal, stallVal, pcVal, expVal);
      if (nItems != 8) begin
         noteFailure($sformatf("stimulus line %0d could not be read", lineNo));
         return;
      end
      if (testNum != curTest) begin
         if (curTest >= 0) begin
            closeTest();
         end
         curTest    = testNum;
         testErrors = 0;
      end
      if (kind == "st") begin
         runStore(opVal[5:0], addrVal, dataVal, stallVal[0], pcVal);
      end else if (kind == "ld" && stallVal[0]) begin
         runStalledLoad(opVal[5:0], addrVal);
      end else if (kind == "ld") begin
         runLoad(opVal[5:0], addrVal, expVal);
      end else if (kind == "fe") begin
         runFetch(addrVal, expVal);
      end else begin
         noteFailure($sformatf("unknown operation kind on stimulus line %0d", lineNo));
      end
   endtask

   initial begin
      applyIdle();
      fetchAddr   = 32'h0;
      rstN        = 1'b0;
      curTest     = -1;
      testErrors  = 0;
      totalErrors = 0;
      passCount   = 0;
      failCount   = 0;
      lineNo      = 0;
      fd = $fopen("bench/memStageStimulus.txt", "r");
      repeat (resetCycles) @(posedge clk);
      #driveDelay;
      rstN = 1'b1;
      if (fd == 0) begin
         $display("cannot open stimulus file bench/memStageStimulus.txt");
         totalErrors++;
      end else begin
         while (!$feof(fd)) begin
            lineText = "";
            if ($fgets(lineText, fd) > 0) begin
               lineNo++;
               runLine();
            end
         end
         $fclose(fd);
         if (curTest >= 0) begin
            closeTest();
         end
      end
      $display("summary: %0d tests ok, %0d tests with errors, %0d errors in all",
               passCount, failCount, totalErrors);
      if (totalErrors == 0 && passCount > 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

// ==== compile.f ====
verilog/memPkg.sv
verilog/writeEnCtr.sv
verilog/storeAlign.sv
verilog/byteMem.sv
verilog/loadExtract.sv
verilog/memStage.sv
bench/memStageTb.sv

// ==== run.sh ====
#!/bin/sh
# build the memory stage testbench with Verilator, run it, judge the log

logFile=sim.log
buildDir=obj_dir
simExe=simMemStage

verilator --binary --timing --assert --timescale 1ns/100ps \
   --top-module memStageTb -Mdir "$buildDir" -o "$simExe" -f compile.f
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
   echo "verilator build failed with status $buildStatus"
   exit 1
fi

"$buildDir/$simExe" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
   echo "simulation exited with status $simStatus"
   exit 1
fi

if grep -qx "TESTS PASSED" "$logFile"; then
   echo "result: pass"
   exit 0
fi
echo "result: fail, see $logFile"
exit 1

// ==== verilog/byteMem.sv ====
module byteMem #(
   parameter int addrW = 10
) (
   input  logic                     clk,
   input  logic [3:0]               we,
   input  logic [addrW-1:0]         wAddr,
   input  logic [memPkg::wordW-1:0] wData,
   input  logic [addrW-1:0]         rAddrA,
   input  logic [addrW-1:0]         rAddrB,
   output logic [memPkg::wordW-1:0] rDataA,
   output logic [memPkg::wordW-1:0] rDataB
);
   import memPkg::*;

   localparam int depth = 1 << addrW;
   localparam int lanes = wordW / 8;

   logic [wordW-1:0] mem [depth];

   // one byte lane per enable bit
   always_ff @(posedge clk) begin
      for (int i = 0; i < lanes; i++) begin
         if (we[i]) begin
            mem[wAddr][8*i +: 8] <= wData[8*i +: 8];
         end
      end
   end

   // registered reads, same-edge write shows old word
   always_ff @(posedge clk) begin
      rDataA <= mem[rAddrA];
   end

   always_ff @(posedge clk) begin
      rDataB <= mem[rAddrB];   // fetch side on instr memory
   end

   // an X in the enables would corrupt lanes silently
   weKnown: assert property (@(posedge clk) !$isunknown(we))
      else $error("byte write enable has unknown bits");

endmodule

// ==== verilog/loadExtract.sv ====
module loadExtract (
   input  logic                     clk,
   input  logic                     rstN,
   input  logic                     loadReq,
   input  logic [5:0]               opcode,
   input  logic [1:0]               byteOffset,
   input  logic [memPkg::wordW-1:0] rData,
   output logic [memPkg::wordW-1:0] loadData,
   output logic                     loadValid
);
   import memPkg::*;

   logic             reqQ;
   logic [5:0]       opQ;
   logic [1:0]       offQ;
   logic [7:0]       selByte;
   logic [15:0]      selHalf;
   logic [wordW-1:0] extWord;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         reqQ <= 1'b0;
      end else begin
         reqQ <= loadReq;
      end
   end

   // held alongside the request, lines up with the memory read
   always_ff @(posedge clk) begin
      if (loadReq) begin
         opQ  <= opcode;
         offQ <= byteOffset;
      end
   end

   assign selByte = rData[wordW-8-8*offQ +: 8];   // offset 0 is 31:24
   assign selHalf = offQ[1] ? rData[15:0] : rData[31:16];

   always_comb begin
      case (opQ)
         opLb:    extWord = {{(wordW-8){selByte[7]}}, selByte};
         opLbu:   extWord = {{(wordW-8){1'b0}}, selByte};
         opLh:    extWord = {{(wordW-16){selHalf[15]}}, selHalf};
         opLhu:   extWord = {{(wordW-16){1'b0}}, selHalf};
         default: extWord = rData;                   // lw
      endcase
   end

   assign loadData  = (reqQ && isLoad(opQ)) ? extWord : '0;
   assign loadValid = reqQ;

   validLowAfterReset: assert property (@(posedge clk) $rose(rstN) |-> !loadValid)
      else $error("loadValid high right after reset release");

endmodule

// ==== verilog/memPkg.sv ====
package memPkg;

   // MIPS store opcodes
   localparam logic [5:0] opSb  = 6'h28;
   localparam logic [5:0] opSh  = 6'h29;
   localparam logic [5:0] opSw  = 6'h2b;

   // MIPS load opcodes
   localparam logic [5:0] opLb  = 6'h20;
   localparam logic [5:0] opLh  = 6'h21;
   localparam logic [5:0] opLw  = 6'h23;
   localparam logic [5:0] opLbu = 6'h24;
   localparam logic [5:0] opLhu = 6'h25;

   localparam int wordW = 32;

   // top nibble of the address picks the region
   localparam int nibbleDataBit  = 0;
   localparam int nibbleInstrBit = 1;

   // boot region flag in the pc
   localparam int pcBootBit = 30;

   function automatic logic isStore(input logic [5:0] op);
      return op inside {opSb, opSh, opSw};
   endfunction

   function automatic logic isLoad(input logic [5:0] op);
      return op inside {opLb, opLbu, opLh, opLhu, opLw};
   endfunction

endpackage

// ==== verilog/memStage.sv ====
module memStage #(
   parameter int dataAddrW  = 10,
   parameter int instrAddrW = 10
) (
   input  logic                     clk,
   input  logic                     rstN,
   input  logic [5:0]               opcode,
   input  logic [memPkg::wordW-1:0] aluOut,
   input  logic [memPkg::wordW-1:0] storeData,
   input  logic                     stall,
   input  logic [memPkg::wordW-1:0] pc,
   input  logic [memPkg::wordW-1:0] fetchAddr,
   output logic [memPkg::wordW-1:0] loadData,
   output logic                     loadValid,
   output logic [memPkg::wordW-1:0] instrWord
);
   import memPkg::*;

   logic [1:0]            byteOffset;
   logic [3:0]            topNibble;
   logic [3:0]            dataWe;
   logic [3:0]            instrWe;
   logic [wordW-1:0]      laneData;
   logic [dataAddrW-1:0]  dataIdx;
   logic [instrAddrW-1:0] instrIdx;
   logic [instrAddrW-1:0] fetchIdx;
   logic [wordW-1:0]      dataRdWord;
   logic                  inDataRegion;
   logic                  loadReq;

   assign byteOffset = aluOut[1:0];
   assign topNibble  = aluOut[wordW-1 -: 4];
   assign dataIdx    = aluOut[dataAddrW+1:2];     // word index
   assign instrIdx   = aluOut[instrAddrW+1:2];
   assign fetchIdx   = fetchAddr[instrAddrW+1:2];

   assign inDataRegion = (topNibble[3:2] == 2'b00) && topNibble[nibbleDataBit];
   assign loadReq      = isLoad(opcode) && !stall && inDataRegion;   // stalled load dropped

   writeEnCtr u_writeEnCtr (
      .opcode     (opcode),
      .byteOffset (byteOffset),
      .aluOut     (aluOut),
      .stall      (stall),
      .pc         (pc),
      .dataWe     (dataWe),
      .instrWe    (instrWe)
   );

   storeAlign u_storeAlign (
      .opcode    (opcode),
      .storeData (storeData),
      .laneData  (laneData)
   );

   byteMem #(.addrW(dataAddrW)) dataMem (
      .clk    (clk),
      .we     (dataWe),
      .wAddr  (dataIdx),
      .wData  (laneData),
      .rAddrA (dataIdx),
      .rAddrB (dataIdx),
      .rDataA (dataRdWord),
      .rDataB ()
   );

   // port B serves instruction fetch
   byteMem #(.addrW(instrAddrW)) instrMem (
      .clk    (clk),
      .we     (instrWe),
      .wAddr  (instrIdx),
      .wData  (laneData),
      .rAddrA (instrIdx),
      .rAddrB (fetchIdx),
      .rDataA (),
      .rDataB (instrWord)
   );

   loadExtract u_loadExtract (
      .clk        (clk),
      .rstN       (rstN),
      .loadReq    (loadReq),
      .opcode     (opcode),
      .byteOffset (byteOffset),
      .rData      (dataRdWord),
      .loadData   (loadData),
      .loadValid  (loadValid)
   );

endmodule

// ==== verilog/storeAlign.sv ====
module storeAlign (
   input  logic [5:0]               opcode,
   input  logic [memPkg::wordW-1:0] storeData,
   output logic [memPkg::wordW-1:0] laneData
);
   import memPkg::*;

   localparam int byteLanes = wordW / 8;
   localparam int halfLanes = wordW / 16;

   // replicate into every lane, the write mask picks the one written
   always_comb begin
      laneData = '0;
      if (isStore(opcode)) begin
         case (opcode)
            opSb: begin
               laneData = {byteLanes{storeData[7:0]}};
            end
            opSh: begin
               laneData = {halfLanes{storeData[15:0]}};
            end
            default: begin
               laneData = storeData;            // full word
            end
         endcase
      end
   end

endmodule

// ==== verilog/writeEnCtr.sv ====
module writeEnCtr (
   input  logic [5:0]               opcode,
   input  logic [1:0]               byteOffset,
   input  logic [memPkg::wordW-1:0] aluOut,
   input  logic                     stall,
   input  logic [memPkg::wordW-1:0] pc,
   output logic [3:0]               dataWe,
   output logic [3:0]               instrWe
);
   import memPkg::*;

   logic [3:0] topNibble;
   logic       isDataMem;
   logic       isInstrMem;
   logic       bootPc;
   logic [3:0] sizeMask;

   assign topNibble = aluOut[wordW-1 -: 4];

   // nibble 3 hits both regions
   assign isDataMem  = (topNibble[3:2] == 2'b00) && topNibble[nibbleDataBit];
   assign isInstrMem = (topNibble[3:2] == 2'b00) && topNibble[nibbleInstrBit];
   assign bootPc     = pc[pcBootBit];    // executing from boot region

   // lane mask by store size and offset
   always_comb begin
      sizeMask = 4'b0000;
      if (isStore(opcode)) begin
         case (opcode)
            opSb: begin
               sizeMask = 4'b1000 >> byteOffset;   // big-endian byte
            end
            opSh: begin
               if (byteOffset[1]) begin
                  sizeMask = 4'b0011;
               end else begin
                  sizeMask = 4'b1100;
               end
            end
            default: begin
               sizeMask = 4'b1111;                 // sw
            end
         endcase
      end
   end

   // a stalled store reaches neither memory
   assign dataWe  = (!stall && isDataMem) ? sizeMask : 4'b0000;
   assign instrWe = (!stall && isInstrMem && bootPc) ? sizeMask : 4'b0000;

endmodule
